// File: source/i2c_bridge_pkg.sv
// Shared types and constants for the stream to I2C bridge, imported by each design unit
`default_nettype none

package i2c_bridge_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int BYTE_W     = 8;   // Stream byte
    localparam int ADDR_W     = 7;   // I2C device address
    localparam int PRESCALE_W = 16;  // I2C core prescale
    localparam int STATUS_W   = 4;   // Meaningful bits of a status reply

    // ----------------------------------------------------------------------
    // Command byte layout
    // ----------------------------------------------------------------------
    localparam int CMD_BIT_START  = 0;
    localparam int CMD_BIT_READ   = 1;
    localparam int CMD_BIT_MULTI  = 2;  // Write-multiple instead of single write
    localparam int CMD_BIT_STOP   = 3;
    localparam int CMD_MODE_LO    = 4;  // Prescale mode field, bits 6..4
    localparam int CMD_MODE_HI    = 6;
    localparam int CMD_BIT_STATUS = 7;  // Only meaningful together with the read bit

    // Mode codes in the prescale field
    localparam logic [2:0] MODE_STANDARD  = 3'b001;
    localparam logic [2:0] MODE_FAST      = 3'b010;
    localparam logic [2:0] MODE_FAST_PLUS = 3'b100;

    // Prescale values for each mode
    localparam logic [PRESCALE_W-1:0] PRESCALE_STANDARD  = 16'd250;
    localparam logic [PRESCALE_W-1:0] PRESCALE_FAST      = 16'd64;
    localparam logic [PRESCALE_W-1:0] PRESCALE_FAST_PLUS = 16'd25;
    localparam logic [PRESCALE_W-1:0] PRESCALE_RESET     = 16'd64;  // Fast mode out of reset

    // ----------------------------------------------------------------------
    // Enums
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_WRITE,        // Single write
        OP_WRITE_MULTI,  // Write-multiple
        OP_READ
    } i2c_op_e;

    typedef enum logic [2:0] {
        IDLE,       // Waiting for a command byte
        GET_ADDR,   // Waiting for the device address
        GET_COUNT,  // Read only, waiting for the byte count
        ISSUE_CMD,  // Command held on the I2C command port
        BUSY_JOB    // An engine owns the packet
    } parser_state_e;

endpackage

`default_nettype wire

// File: source/bridge_job_if.sv
// Job and write payload link from the header parser to the write and read engines
`timescale 1ns/10ps
`default_nettype none

interface bridge_job_if
    import i2c_bridge_pkg::*;
#(
    parameter int COUNT_W = 8
) ();

    logic               job_start;  // One-cycle pulse as the I2C command transfers
    i2c_op_e            job_op;
    logic [COUNT_W-1:0] job_count;  // Read byte count, zero means full range

    logic               pay_valid;  // Payload, straight from the input stream
    logic               pay_ready;
    logic [BYTE_W-1:0]  pay_data;
    logic               pay_last;

    logic               wr_done;    // Per-engine completion pulses
    logic               rd_done;
    logic               job_done;

    assign job_done = wr_done | rd_done;  // Only one engine runs at a time

    modport parser (
        output job_start, job_op, job_count, pay_valid, pay_data, pay_last,
        input  pay_ready, job_done
    );

    modport writer (
        input  job_start, job_op, pay_valid, pay_data, pay_last,
        output pay_ready, wr_done
    );

    modport reader (
        input  job_start, job_op, job_count,
        output rd_done
    );

endinterface

`default_nettype wire

// File: source/header_parser.sv
// Packet header decoder, issues one I2C command per packet and answers status queries
`timescale 1ns/10ps
`default_nettype none

module header_parser
    import i2c_bridge_pkg::*;
#(
    parameter int COUNT_W = 8
) (
    input  wire                    clk,
    input  wire                    rst,
    // Input stream
    input  wire                    sw_tvalid,
    output logic                   sw_tready,
    input  wire  [BYTE_W-1:0]      sw_tdata,
    input  wire                    sw_tlast,
    // I2C command port
    output logic [ADDR_W-1:0]      cmd_address,
    output logic                   cmd_start,
    output logic                   cmd_read,
    output logic                   cmd_write,
    output logic                   cmd_write_multiple,
    output logic                   cmd_stop,
    output logic                   cmd_valid,
    input  wire                    cmd_ready,
    output logic [PRESCALE_W-1:0]  prescale,
    // Core status
    input  wire                    busy,
    input  wire                    bus_control,
    input  wire                    bus_active,
    input  wire                    missed_ack,
    // Status reply offer
    output logic                   st_valid,
    output logic [BYTE_W-1:0]      st_data,
    input  wire                    st_ready,
    bridge_job_if.parser           job
);

    parser_state_e      state;
    i2c_op_e            op_q;
    logic [COUNT_W-1:0] count_q;
    logic               sw_take;

    assign sw_take = sw_tvalid && sw_tready;

    always_comb begin
        case (state)
            IDLE:                sw_tready = !st_valid;     // Hold off while a status byte waits
            GET_ADDR, GET_COUNT: sw_tready = 1'b1;
            BUSY_JOB:            sw_tready = job.pay_ready; // Engine paces the payload
            default:             sw_tready = 1'b0;          // ISSUE_CMD
        endcase
    end

    // Payload passes straight through while an engine owns the packet
    assign job.pay_valid = (state == BUSY_JOB) && sw_tvalid;
    assign job.pay_data  = sw_tdata;
    assign job.pay_last  = sw_tlast;
    assign job.job_start = cmd_valid && cmd_ready;  // Command transfer starts the job
    assign job.job_op    = op_q;
    assign job.job_count = count_q;

    assign cmd_read           = (op_q == OP_READ);
    assign cmd_write          = (op_q == OP_WRITE);
    assign cmd_write_multiple = (op_q == OP_WRITE_MULTI);

    // ----------------------------------------------------------------------
    // Header FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= IDLE;
            op_q      <= OP_WRITE;
            cmd_valid <= 1'b0;
            st_valid  <= 1'b0;
            prescale  <= PRESCALE_RESET;
        end else begin
            if (st_valid && st_ready)
                st_valid <= 1'b0;   // Reply stage took the status byte
            case (state)
                IDLE: begin
                    if (sw_take) begin
                        case (sw_tdata[CMD_MODE_HI:CMD_MODE_LO])
                            MODE_STANDARD:  prescale <= PRESCALE_STANDARD;
                            MODE_FAST:      prescale <= PRESCALE_FAST;
                            MODE_FAST_PLUS: prescale <= PRESCALE_FAST_PLUS;
                            default:        ;  // Other codes keep the prescale
                        endcase
                        if (sw_tdata[CMD_BIT_READ] && sw_tdata[CMD_BIT_STATUS]) begin
                            st_valid <= 1'b1;  // Status query, no I2C command
                            st_data  <= {{(BYTE_W-STATUS_W){1'b0}},
                                         bus_active, bus_control, busy, missed_ack};
                        end else begin
                            cmd_start <= sw_tdata[CMD_BIT_START];
                            cmd_stop  <= sw_tdata[CMD_BIT_STOP];
                            if (sw_tdata[CMD_BIT_READ])
                                op_q <= OP_READ;
                            else if (sw_tdata[CMD_BIT_MULTI])
                                op_q <= OP_WRITE_MULTI;
                            else
                                op_q <= OP_WRITE;
                            state <= GET_ADDR;
                        end
                    end
                end
                GET_ADDR: begin
                    if (sw_take) begin
                        cmd_address <= sw_tdata[ADDR_W-1:0];
                        if (op_q == OP_READ) begin
                            state <= GET_COUNT;
                        end else begin
                            cmd_valid <= 1'b1;  // Address is the last write header byte
                            state     <= ISSUE_CMD;
                        end
                    end
                end
                GET_COUNT: begin
                    if (sw_take) begin
                        count_q   <= COUNT_W'(sw_tdata);
                        cmd_valid <= 1'b1;
                        state     <= ISSUE_CMD;
                    end
                end
                ISSUE_CMD: begin
                    if (cmd_ready) begin
                        cmd_valid <= 1'b0;
                        state     <= BUSY_JOB;
                    end
                end
                BUSY_JOB: begin
                    if (job.job_done)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // The I2C core may stall the command for any number of cycles
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst)
        cmd_valid && !cmd_ready |=> cmd_valid);

endmodule

`default_nettype wire

// File: source/write_engine.sv
// Write engine, moves payload bytes to the I2C write port and drains after a missed ack
`timescale 1ns/10ps
`default_nettype none

module write_engine
    import i2c_bridge_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    bridge_job_if.writer       job,
    // I2C write data port
    output logic [BYTE_W-1:0]  data_tdata,
    output logic               data_tvalid,
    input  wire                data_tready,
    output logic               data_tlast,
    input  wire                missed_ack
);

    logic active;     // A write job owns the payload
    logic drop;       // Missed ack seen, discard the rest
    logic ack_q;
    logic ack_rise;
    logic pay_take;
    logic data_take;

    assign ack_rise      = missed_ack && !ack_q;
    assign job.pay_ready = active && !data_tvalid;  // One byte in flight
    assign pay_take      = job.pay_valid && job.pay_ready;
    assign data_take     = data_tvalid && data_tready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            active      <= 1'b0;
            drop        <= 1'b0;
            ack_q       <= 1'b0;
            data_tvalid <= 1'b0;
            job.wr_done <= 1'b0;
        end else begin
            ack_q       <= missed_ack;
            job.wr_done <= 1'b0;
            if (job.job_start && job.job_op != OP_READ) begin
                active <= 1'b1;
                drop   <= 1'b0;
            end
            if (active && ack_rise)
                drop <= 1'b1;

            // Held byte leaves, a held last byte ends the job
            if (data_take) begin
                data_tvalid <= 1'b0;
                if (data_tlast) begin
                    active      <= 1'b0;
                    job.wr_done <= 1'b1;
                end
            end

            if (pay_take) begin
                if (drop || ack_rise) begin
                    if (job.pay_last) begin  // Drained up to the packet end
                        active      <= 1'b0;
                        job.wr_done <= 1'b1;
                    end
                end else begin
                    data_tdata  <= job.pay_data;
                    data_tvalid <= 1'b1;
                    data_tlast  <= job.pay_last;
                end
            end
        end
    end

    // Byte must not change under back-pressure from the core
    a_data_hold: assert property (@(posedge clk) disable iff (!rst)
        data_tvalid && !data_tready |=> data_tvalid && $stable(data_tdata));

endmodule

`default_nettype wire

// File: source/read_engine.sv
// Read engine, collects the requested number of bytes from the I2C read port
`timescale 1ns/10ps
`default_nettype none

module read_engine
    import i2c_bridge_pkg::*;
#(
    parameter int COUNT_W = 8
) (
    input  wire                clk,
    input  wire                rst,
    bridge_job_if.reader       job,
    // I2C read data port
    input  wire  [BYTE_W-1:0]  rd_tdata,
    input  wire                rd_tvalid,
    output logic               rd_tready,
    input  wire                missed_ack,
    // Read byte offer to the reply stage
    output logic               rr_valid,
    output logic [BYTE_W-1:0]  rr_data,
    output logic               rr_last,
    input  wire                rr_ready
);

    logic               active;
    logic               abort;  // Missed ack, stop taking bytes
    logic               ack_q;
    logic [COUNT_W-1:0] left;   // Bytes still to take, wraps from zero for full range
    logic               rd_take;
    logic               rr_take;

    assign rd_tready = active && !abort && !rr_valid;  // Waits for the reply port
    assign rd_take   = rd_tvalid && rd_tready;
    assign rr_take   = rr_valid && rr_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            active      <= 1'b0;
            abort       <= 1'b0;
            ack_q       <= 1'b0;
            rr_valid    <= 1'b0;
            job.rd_done <= 1'b0;
        end else begin
            ack_q       <= missed_ack;
            job.rd_done <= 1'b0;
            if (job.job_start && job.job_op == OP_READ) begin
                active <= 1'b1;
                abort  <= 1'b0;
                left   <= job.job_count;
            end
            if (active && missed_ack && !ack_q)
                abort <= 1'b1;

            // Capture, then offer one cycle later
            if (rd_take) begin
                rr_data  <= rd_tdata;
                rr_valid <= 1'b1;
                rr_last  <= (left == COUNT_W'(1));
                left     <= left - 1'b1;
            end

            if (rr_take) begin
                rr_valid <= 1'b0;
                if (rr_last) begin
                    active      <= 1'b0;
                    job.rd_done <= 1'b1;
                end
            end else if (active && abort && !rr_valid) begin
                active      <= 1'b0;  // Early end, nothing more is offered
                job.rd_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/reply_stage.sv
// Reply stream output register, merges status replies and read bytes
`timescale 1ns/10ps
`default_nettype none

module reply_stage
    import i2c_bridge_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    // Status offer from the header parser
    input  wire                st_valid,
    input  wire  [BYTE_W-1:0]  st_data,
    output logic               st_ready,
    // Read byte offer from the read engine
    input  wire                rr_valid,
    input  wire  [BYTE_W-1:0]  rr_data,
    input  wire                rr_last,
    output logic               rr_ready,
    // Reply stream
    output logic [BYTE_W-1:0]  reply_tdata,
    output logic               reply_tvalid,
    input  wire                reply_tready,
    output logic               reply_tlast
);

    logic free;

    assign free     = !reply_tvalid || reply_tready;  // Empty, or emptying this cycle
    assign st_ready = free;
    assign rr_ready = free && !st_valid;              // Status wins a tie

    always_ff @(posedge clk) begin
        if (!rst) begin
            reply_tvalid <= 1'b0;
        end else if (st_valid && st_ready) begin
            reply_tvalid <= 1'b1;
            reply_tdata  <= st_data;
            reply_tlast  <= 1'b1;    // Status reply is always a one-byte packet
        end else if (rr_valid && rr_ready) begin
            reply_tvalid <= 1'b1;
            reply_tdata  <= rr_data;
            reply_tlast  <= rr_last;
        end else if (reply_tready) begin
            reply_tvalid <= 1'b0;
        end
    end

    // Parser only queries status from IDLE, read engine only offers in BUSY_JOB
    a_one_offer: assert property (@(posedge clk) disable iff (!rst)
        !(st_valid && rr_valid));

endmodule

`default_nettype wire

// File: source/i2c_stream_bridge.sv
// Top level of the byte stream to I2C master bridge, instances and wiring only
`timescale 1ns/10ps
`default_nettype none

module i2c_stream_bridge
    import i2c_bridge_pkg::*;
#(
    parameter int COUNT_W = 8
) (
    input  wire                    clk,
    input  wire                    rst,
    // Input stream
    input  wire                    sw_tvalid,
    output logic                   sw_tready,
    input  wire  [BYTE_W-1:0]      sw_tdata,
    input  wire                    sw_tlast,
    // I2C command
    output logic [ADDR_W-1:0]      cmd_address,
    output logic                   cmd_start,
    output logic                   cmd_read,
    output logic                   cmd_write,
    output logic                   cmd_write_multiple,
    output logic                   cmd_stop,
    output logic                   cmd_valid,
    input  wire                    cmd_ready,
    // I2C write data
    output logic [BYTE_W-1:0]      data_tdata,
    output logic                   data_tvalid,
    input  wire                    data_tready,
    output logic                   data_tlast,
    // I2C read data, the count marks the end so rd_tlast has no load
    input  wire  [BYTE_W-1:0]      rd_tdata,
    input  wire                    rd_tvalid,
    output logic                   rd_tready,
    input  wire                    rd_tlast,
    // Core status
    input  wire                    busy,
    input  wire                    bus_control,
    input  wire                    bus_active,
    input  wire                    missed_ack,
    // Reply stream
    output logic [BYTE_W-1:0]      reply_tdata,
    output logic                   reply_tvalid,
    input  wire                    reply_tready,
    output logic                   reply_tlast,
    output logic [PRESCALE_W-1:0]  prescale
);

    // ----------------------------------------------------------------------
    // Internal links
    // ----------------------------------------------------------------------
    logic              st_valid;   // Status offer
    logic              st_ready;
    logic [BYTE_W-1:0] st_data;
    logic              rr_valid;   // Read byte offer
    logic              rr_ready;
    logic [BYTE_W-1:0] rr_data;
    logic              rr_last;

    bridge_job_if #(.COUNT_W(COUNT_W)) job_bus ();

    header_parser #(.COUNT_W(COUNT_W)) u_parser (
        .clk, .rst,
        .sw_tvalid, .sw_tready, .sw_tdata, .sw_tlast,
        .cmd_address, .cmd_start, .cmd_read, .cmd_write, .cmd_write_multiple,
        .cmd_stop, .cmd_valid, .cmd_ready,
        .prescale,
        .busy, .bus_control, .bus_active, .missed_ack,
        .st_valid, .st_data, .st_ready,
        .job (job_bus.parser)
    );

    write_engine u_writer (
        .clk, .rst,
        .job (job_bus.writer),
        .data_tdata, .data_tvalid, .data_tready, .data_tlast,
        .missed_ack
    );

    read_engine #(.COUNT_W(COUNT_W)) u_reader (
        .clk, .rst,
        .job (job_bus.reader),
        .rd_tdata, .rd_tvalid, .rd_tready,
        .missed_ack,
        .rr_valid, .rr_data, .rr_last, .rr_ready
    );

    reply_stage u_reply (
        .clk, .rst,
        .st_valid, .st_data, .st_ready,
        .rr_valid, .rr_data, .rr_last, .rr_ready,
        .reply_tdata, .reply_tvalid, .reply_tready, .reply_tlast
    );

endmodule

`default_nettype wire

// File: testbench/tb_checks.svh
// Testbench helpers included in tb_bridge for LFSR stimulus, expected queues and compare tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------------------------------------
// Expected command as the header describes it
// ----------------------------------------------------------------------
typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              start;
    logic              stop;
    i2c_op_e           op;
} cmd_t;

cmd_t              cmd_q[$];   // Commands still to appear
logic [BYTE_W:0]   wr_q[$];    // {last, data} on the I2C write port
logic [BYTE_W:0]   rep_q[$];   // {last, data} on the reply stream
int                err_count   = 0;
int                check_count = 0;
logic [15:0]       lfsr        = 16'd16911;  // Galois LFSR state

// Takes n bits with one LFSR step per bit
function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v    = {v[14:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // Taps 16,14,13,11
    end
    return v;
endfunction

task automatic check_cmd(input string name, input cmd_t exp, input logic [ADDR_W-1:0] addr,
                         input logic start, input logic stop, input logic rd,
                         input logic wr, input logic wrm);
    i2c_op_e exp_op;
    string   exp_s;
    string   act_s;
    exp_op = exp.op;
    check_count++;
    if (addr !== exp.addr || start !== exp.start || stop !== exp.stop
        || rd !== (exp_op == OP_READ) || wr !== (exp_op == OP_WRITE)
        || wrm !== (exp_op == OP_WRITE_MULTI)) begin
        err_count++;
        exp_s = $sformatf("addr %h start %b stop %b op %s",
                          exp.addr, exp.start, exp.stop, exp_op.name());
        act_s = $sformatf("addr %h start %b stop %b rd/wr/wrm %b%b%b",
                          addr, start, stop, rd, wr, wrm);
        $display("** Error %s: expected %s, actual %s", name, exp_s, act_s);
    end
endtask

task automatic check_wr(input string name, input logic [BYTE_W:0] exp,
                        input logic [BYTE_W:0] act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("** Error %s: expected last %b data %h, actual last %b data %h",
                 name, exp[BYTE_W], exp[BYTE_W-1:0], act[BYTE_W], act[BYTE_W-1:0]);
    end
endtask

task automatic check_reply(input string name, input logic [BYTE_W:0] exp,
                           input logic [BYTE_W:0] act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("** Error %s: expected last %b data %h, actual last %b data %h",
                 name, exp[BYTE_W], exp[BYTE_W-1:0], act[BYTE_W], act[BYTE_W-1:0]);
    end
endtask

task automatic check_prescale(input string name, input logic [PRESCALE_W-1:0] exp,
                              input logic [PRESCALE_W-1:0] act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

// A transfer that nothing was waiting for
task automatic no_expect(input string what);
    err_count++;
    $display("Unexpected %s transfer with nothing left to expect", what);
endtask

`endif

// File: testbench/tb_bridge.sv
// Testbench top that drives random packets into the stream to I2C bridge against an I2C core model
`timescale 1ns/10ps
`default_nettype none

module tb_bridge
    import i2c_bridge_pkg::*;
;

    localparam int NUM_PKT = 60;

    logic                  clk = 1'b0;
    logic                  rst = 1'b0;
    logic                  sw_tvalid, sw_tready, sw_tlast;
    logic [BYTE_W-1:0]     sw_tdata;
    logic [ADDR_W-1:0]     cmd_address;
    logic                  cmd_start, cmd_read, cmd_write, cmd_write_multiple, cmd_stop;
    logic                  cmd_valid, cmd_ready;
    logic [BYTE_W-1:0]     data_tdata, rd_tdata, reply_tdata;
    logic                  data_tvalid, data_tready, data_tlast;
    logic                  rd_tvalid, rd_tready, rd_tlast;
    logic                  busy, bus_control, bus_active, missed_ack;
    logic                  reply_tvalid, reply_tready, reply_tlast;
    logic [PRESCALE_W-1:0] prescale;

    `include "tb_checks.svh"

    // Core model and sequencing state
    logic [PRESCALE_W-1:0] exp_prescale = PRESCALE_RESET;
    int  byte_total = 0;   // Bytes generated so far for the timeout limit
    int  cycles     = 0;
    int  wr_cnt, wr_ack_at, rd_cnt, rd_ack_at, rd_n, rd_pending;
    logic rd_taken, ack_due;

    always #10 clk = ~clk;  // 20 ns period

    i2c_stream_bridge #(.COUNT_W(8)) dut0 (.*);

    // ----------------------------------------------------------------------
    // I2C core model sampling transfers at the edge and driving 1 ns later
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        rd_taken = rd_tvalid && rd_tready;
        ack_due  = 1'b0;
        if (rst) begin
            if (cmd_valid && cmd_ready) begin
                if (cmd_q.size() == 0)
                    no_expect("I2C command");
                else
                    check_cmd("command", cmd_q.pop_front(), cmd_address, cmd_start,
                              cmd_stop, cmd_read, cmd_write, cmd_write_multiple);
            end
            if (data_tvalid && data_tready) begin
                wr_cnt++;
                if (wr_q.size() == 0)
                    no_expect("write data");
                else
                    check_wr("write data", wr_q.pop_front(), {data_tlast, data_tdata});
                ack_due = (wr_cnt == wr_ack_at);  // NAK right after this byte
            end
            if (rd_taken) begin
                if (rd_pending <= 0) begin
                    no_expect("I2C read");        // Read past the count or after a NAK
                end else begin
                    rd_cnt++;
                    rd_pending--;
                    rep_q.push_back({rd_cnt == rd_n, rd_tdata});  // Last only on byte N
                    if (rd_cnt == rd_ack_at) begin
                        ack_due    = 1'b1;
                        rd_pending = 0;               // Read ends early
                    end
                end
            end
            if (reply_tvalid && reply_tready) begin
                if (rep_q.size() == 0)
                    no_expect("reply");
                else
                    check_reply("reply", rep_q.pop_front(), {reply_tlast, reply_tdata});
            end
        end
        #1;
        cmd_ready    = take_bits(1);
        data_tready  = take_bits(1);
        reply_tready = take_bits(1);
        if (!(rd_tvalid && !rd_taken)) begin  // Hold an offered byte until taken
            rd_tvalid = take_bits(1);
            rd_tdata  = take_bits(BYTE_W);
        end
        if (ack_due)
            missed_ack = 1'b1;
    end

    // Watchdog scaled by the generated traffic
    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * byte_total + 200) begin
            $display("Timeout after %0d cycles, the DUT stopped moving bytes", cycles);
            $display("Checks: %0d, errors: %0d", check_count, err_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Offers one input byte and waits for the handshake
    task automatic send_byte(input logic [BYTE_W-1:0] data, input logic last,
                             input logic is_cmd);
        if (take_bits(2) == 0) begin
            @(posedge clk);     // Random idle gap
            #1;
        end
        sw_tvalid = 1'b1;
        sw_tdata  = data;
        sw_tlast  = last;
        @(posedge clk);
        while (!sw_tready)
            @(posedge clk);
        #1;
        sw_tvalid = 1'b0;
        if (is_cmd) begin
            case (data[6:4])
                3'b001:  exp_prescale = 16'd250;
                3'b010:  exp_prescale = 16'd64;
                3'b100:  exp_prescale = 16'd25;
                default: ;                          // Unchanged
            endcase
            check_prescale("prescale", exp_prescale, prescale);
        end
    endtask

    // Waits until every expected transfer has been seen
    task automatic wait_idle();
        while (cmd_q.size() != 0 || wr_q.size() != 0 || rep_q.size() != 0
               || rd_pending > 0 || cmd_valid || data_tvalid || reply_tvalid)
            @(posedge clk);
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic run_packet();
        logic [BYTE_W-1:0] cmd;
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] data[8];
        int kind;
        int n;
        missed_ack  = 1'b0;
        busy        = take_bits(1);
        bus_control = take_bits(1);
        bus_active  = take_bits(1);
        wr_cnt      = 0;
        wr_ack_at   = 0;
        rd_cnt      = 0;
        rd_ack_at   = 0;
        cmd         = take_bits(BYTE_W);
        addr        = take_bits(ADDR_W);
        kind        = take_bits(2) % 3;
        if (kind == 0) begin                // Status query
            cmd[7]     = 1'b1;
            cmd[1]     = 1'b1;
            missed_ack = take_bits(1);
            rep_q.push_back({1'b1, 4'b0000, bus_active, bus_control, busy, missed_ack});
            byte_total += 1;
            send_byte(cmd, 1'b1, 1'b1);
        end else if (kind == 1) begin       // Write
            cmd[1] = 1'b0;
            n      = 1 + take_bits(3) % 6;
            cmd_q.push_back(cmd_t'{addr, cmd[0], cmd[3], cmd[2] ? OP_WRITE_MULTI : OP_WRITE});
            if (n >= 2 && take_bits(2) == 0)
                wr_ack_at = 1 + take_bits(3) % (n - 1);
            for (int i = 0; i < n; i++) begin
                data[i] = take_bits(BYTE_W);
                if (wr_ack_at == 0 || i < wr_ack_at)
                    wr_q.push_back({wr_ack_at == 0 && i == n - 1, data[i]});
            end
            byte_total += 2 + n;
            send_byte(cmd, 1'b0, 1'b1);
            send_byte({1'b0, addr}, 1'b0, 1'b0);
            for (int i = 0; i < n; i++)
                send_byte(data[i], i == n - 1, 1'b0);
        end else begin                      // Read
            cmd[1] = 1'b1;
            cmd[7] = 1'b0;
            n      = 1 + take_bits(3);
            cmd_q.push_back(cmd_t'{addr, cmd[0], cmd[3], OP_READ});
            if (n >= 2 && take_bits(2) == 0)
                rd_ack_at = 1 + take_bits(3) % (n - 1);
            rd_n       = n;
            rd_pending = n;
            byte_total += 3 + n;
            send_byte(cmd, 1'b0, 1'b1);
            send_byte({1'b0, addr}, 1'b0, 1'b0);
            send_byte(BYTE_W'(n), 1'b1, 1'b0);
        end
        wait_idle();
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        sw_tvalid    = 1'b0;
        sw_tdata     = '0;
        sw_tlast     = 1'b0;
        cmd_ready    = 1'b0;
        data_tready  = 1'b0;
        rd_tvalid    = 1'b0;
        rd_tdata     = '0;
        rd_tlast     = 1'b0;
        reply_tready = 1'b0;
        busy         = 1'b0;
        bus_control  = 1'b0;
        bus_active   = 1'b0;
        missed_ack   = 1'b0;
        rd_n         = 0;
        rd_pending   = 0;
        wr_cnt       = 0;
        wr_ack_at    = 0;
        rd_cnt       = 0;
        rd_ack_at    = 0;
        repeat (3) @(posedge clk);  // Reset held for 3 cycles
        #1;
        rst = 1'b1;
        check_prescale("reset prescale", PRESCALE_RESET, prescale);
        for (int p = 0; p < NUM_PKT; p++)
            run_packet();
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+testbench
source/i2c_bridge_pkg.sv
source/bridge_job_if.sv
source/header_parser.sv
source/write_engine.sv
source/read_engine.sv
source/reply_stage.sv
source/i2c_stream_bridge.sv
testbench/tb_bridge.sv
